/* src/sync_pkg.sv */
// Shared widths, types and constants for the video sync path, imported by the RTL and testbench
package sync_pkg;

	////////////////////////////////////////////////////////////
	// Counter width and type
	////////////////////////////////////////////////////////////

	// Width of run-length, line-length and sync-length counters
	localparam int CNT_W = 16;

	// Lengths in clock cycles
	typedef logic [CNT_W-1:0] cnt_t;

	// Counters hold here instead of wrapping
	localparam cnt_t CNT_MAX = '1;

	// Saturating increment shared by all length counters
	function automatic cnt_t cnt_inc(input cnt_t value);
		cnt_t result;
		if (value == CNT_MAX) begin
			result = value;
		end else begin
			result = value + cnt_t'(1);
		end
		return result;
	endfunction

	////////////////////////////////////////////////////////////
	// Sync pair and output mode
	////////////////////////////////////////////////////////////

	// Horizontal and vertical sync travelling together
	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

	// Both pins inactive on an active-low VGA connector
	localparam sync_t SYNC_IDLE_N = '{hs: 1'b1, vs: 1'b1};

	// No sync asserted, no inversion detected
	localparam sync_t SYNC_CLEAR = '{hs: 1'b0, vs: 1'b0};

	// How the VGA sync pins are driven
	typedef enum logic {
		SYNC_SEPARATE  = 1'b0,
		SYNC_COMPOSITE = 1'b1
	} sync_mode_e;

endpackage

/* src/sync_polarity_fix.sv */
// Sync polarity normalizer, instantiated once per sync line so the output is always active high
`timescale 1ns/1ps

module sync_polarity_fix
	import sync_pkg::*;
(
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync,
	output logic o_pol
);

	// Two-stage chain used for edge detection
	logic sync_q1;
	logic sync_q2;

	logic edge_rise;
	logic edge_fall;

	// Cycles since the last edge at the chain's end
	cnt_t run_cnt;

	// Last completed low and high runs
	cnt_t low_run;
	cnt_t high_run;

	logic pol;

	////////////////////////////////////////////////////////////
	// Input chain and edge detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end else begin
			sync_q1 <= i_sync;
			sync_q2 <= sync_q1;
		end
	end

	assign edge_rise = sync_q1 & ~sync_q2;
	assign edge_fall = ~sync_q1 & sync_q2;

	////////////////////////////////////////////////////////////
	// Run length measurement
	////////////////////////////////////////////////////////////

	// Restarts on every edge, holds at all ones on a stuck input
	always_ff @(posedge clk) begin
		if (resetd) begin
			run_cnt <= '0;
		end else if (edge_rise || edge_fall) begin
			run_cnt <= '0;
		end else begin
			run_cnt <= cnt_inc(run_cnt);
		end
	end

	// A rising edge ends a low run, a falling edge ends a high run
	always_ff @(posedge clk) begin
		if (resetd) begin
			low_run  <= '0;
			high_run <= '0;
		end else begin
			if (edge_rise) begin
				low_run <= run_cnt;
			end
			if (edge_fall) begin
				high_run <= run_cnt;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Polarity decision
	////////////////////////////////////////////////////////////

	// Sync pulse is the shorter run, so a longer high run means active low
	always_ff @(posedge clk) begin
		if (resetd) begin
			pol <= 1'b0;
		end else begin
			pol <= (high_run > low_run);
		end
	end

	// Zero latency from the raw input
	assign o_sync = i_sync ^ pol;
	assign o_pol  = pol;

endmodule

/* src/csync_gen.sv */
// Composite sync generator, merges normalized hs and vs with serration during vertical sync
`timescale 1ns/1ps

module csync_gen
	import sync_pkg::*;
(
	input  logic  clk,
	input  logic  resetd,
	input  sync_t i_sync,
	output logic  o_csync
);

	// Previous hs for edge detection
	logic hs_prev;

	logic hs_rise;
	logic hs_fall;

	// Cycles since the last hs edge
	cnt_t h_cnt;

	// Measured sync pulse width and remaining part of the line
	cnt_t hs_len;
	cnt_t line_len;

	// Horizontal part of the composite signal
	logic serr;

	// Vertical sync aligned with serr
	logic vs_q;

	////////////////////////////////////////////////////////////
	// Horizontal timing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_prev <= 1'b0;
		end else begin
			hs_prev <= i_sync.hs;
		end
	end

	assign hs_rise = i_sync.hs & ~hs_prev;
	assign hs_fall = ~i_sync.hs & hs_prev;

	// Line and sync counter
	always_ff @(posedge clk) begin
		if (resetd) begin
			h_cnt <= '0;
		end else if (hs_rise || hs_fall) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= cnt_inc(h_cnt);
		end
	end

	// Falling edge closes the sync pulse
	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_len <= '0;
		end else if (hs_fall) begin
			hs_len <= h_cnt;
		end
	end

	// Rising edge closes the gap, stored minus one sync length
	// so the serrated pulse starts one sync length early
	always_ff @(posedge clk) begin
		if (resetd) begin
			line_len <= '0;
		end else if (hs_rise) begin
			line_len <= h_cnt - hs_len;
		end
	end

	////////////////////////////////////////////////////////////
	// Serration
	////////////////////////////////////////////////////////////

	// Outside vs the hs pulse passes through.
	// Inside vs the pulse is shifted left by one sync length,
	// and the set at the line length wins over the clear
	always_ff @(posedge clk) begin
		if (resetd) begin
			serr <= 1'b0;
		end else if (!i_sync.vs) begin
			serr <= i_sync.hs;
		end else if (h_cnt == line_len) begin
			serr <= 1'b1;
		end else if (hs_rise) begin
			serr <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Composite output
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			vs_q <= 1'b0;
		end else begin
			vs_q <= i_sync.vs;
		end
	end

	// During vs the shifted pulses invert into serration notches
	assign o_csync = serr ^ vs_q;

endmodule

/* src/video_sync_top.sv */
// Top level of the sync conditioning path, drives active-low VGA sync in separate or composite mode
`timescale 1ns/1ps

module video_sync_top
	import sync_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,
	input  sync_t      i_sync,
	input  sync_mode_e i_mode,
	output sync_t      o_vga_sync_n,
	output sync_t      o_sync_pol
);

	// Active-high sync after polarity correction
	sync_t norm_sync;

	// Detected polarity per line where 1 means active-low input
	sync_t pol;

	// Composite sync lagging norm_sync by one cycle
	logic  csync;

	// Pin values for the next cycle
	sync_t vga_next;

	////////////////////////////////////////////////////////////
	// Polarity normalizers
	////////////////////////////////////////////////////////////

	sync_polarity_fix i_fix_hs (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.hs),
		.o_sync (norm_sync.hs),
		.o_pol  (pol.hs)
	);

	sync_polarity_fix i_fix_vs (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.vs),
		.o_sync (norm_sync.vs),
		.o_pol  (pol.vs)
	);

	////////////////////////////////////////////////////////////
	// Composite sync
	////////////////////////////////////////////////////////////

	csync_gen i_csync_gen (
		.clk     (clk),
		.resetd  (resetd),
		.i_sync  (norm_sync),
		.o_csync (csync)
	);

	////////////////////////////////////////////////////////////
	// VGA output stage
	////////////////////////////////////////////////////////////

	// Composite mode uses the hs pin only, vs pin stays inactive
	always_comb begin
		unique case (i_mode)
			SYNC_COMPOSITE: begin
				vga_next.hs = ~csync;
				vga_next.vs = 1'b1;
			end
			default: begin
				vga_next.hs = ~norm_sync.hs;
				vga_next.vs = ~norm_sync.vs;
			end
		endcase
	end

	// Both registered pins come out of reset inactive
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_vga_sync_n <= SYNC_IDLE_N;
		end else begin
			o_vga_sync_n <= vga_next;
		end
	end

	// Polarity status
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sync_pol <= SYNC_CLEAR;
		end else begin
			o_sync_pol <= pol;
		end
	end

endmodule

/* test/video_sync_sva.sv */
// Concurrent assertions on the video sync top level, attached to it by the bind at the end
`timescale 1ns/1ps

module video_sync_sva
	import sync_pkg::*;
(
	input logic       clk,
	input logic       resetd,
	input sync_t      i_sync,
	input sync_mode_e i_mode,
	input sync_t      o_vga_sync_n,
	input sync_t      o_sync_pol
);

	// Pins inactive and no inversion one cycle after reset
	a_reset_idle: assert property (@(posedge clk)
		$past(resetd) |-> (o_vga_sync_n.hs && o_vga_sync_n.vs &&
			!o_sync_pol.hs && !o_sync_pol.vs))
		else $error("outputs not idle in the cycle after reset");

	a_composite_vs_high: assert property (@(posedge clk) disable iff (resetd)
		(i_mode == SYNC_COMPOSITE) |=> o_vga_sync_n.vs)
		else $error("vs pin low in composite mode");

	// Raw edge, two sync stages, record, decision, then status register
	a_pol_hs_edge: assert property (@(posedge clk) disable iff (resetd)
		(o_sync_pol.hs != $past(o_sync_pol.hs)) |->
			($past(i_sync.hs, 4) != $past(i_sync.hs, 5)))
		else $error("hs polarity changed without a preceding hs edge");

	a_pol_vs_edge: assert property (@(posedge clk) disable iff (resetd)
		(o_sync_pol.vs != $past(o_sync_pol.vs)) |->
			($past(i_sync.vs, 4) != $past(i_sync.vs, 5)))
		else $error("vs polarity changed without a preceding vs edge");

endmodule

bind video_sync_top video_sync_sva i_video_sync_sva (
	.clk          (clk),
	.resetd       (resetd),
	.i_sync       (i_sync),
	.i_mode       (i_mode),
	.o_vga_sync_n (o_vga_sync_n),
	.o_sync_pol   (o_sync_pol)
);

/* test/tb_video_sync.sv */
// Testbench for the video sync path, drives random sync timings and checks against a cycle model
`timescale 1ns/1ps

module tb_video_sync
	import sync_pkg::*;
();

	localparam int NUM_TESTS       = 8;
	localparam int FRAMES_PER_TEST = 3;
	localparam int RESET_CYCLES    = 8;
	// Longest line times the tallest frame
	localparam int MAX_FRAME       = 200 * 40;
	localparam int TIMEOUT_CYCLES  = NUM_TESTS * FRAMES_PER_TEST * MAX_FRAME + RESET_CYCLES + 1000;

	logic       clk;
	logic       resetd;
	sync_t      i_sync;
	sync_mode_e i_mode;
	sync_t      o_vga_sync_n;
	sync_t      o_sync_pol;

	bit [31:0] rng_state;
	int        err_count;
	int        check_count;
	int        test_count;
	int        cycle_cnt;

	// Model state indexed 0 for hs and 1 for vs
	logic  m_q1 [2];
	logic  m_q2 [2];
	cnt_t  m_run [2];
	cnt_t  m_low [2];
	cnt_t  m_high [2];
	logic  m_pol [2];
	logic  m_hs_prev;
	cnt_t  m_h_cnt;
	cnt_t  m_hs_len;
	cnt_t  m_line_len;
	logic  m_serr;
	logic  m_vs_q;
	sync_t m_out_n;
	sync_t m_pol_out;

	video_sync_top i_video_sync_top (
		.clk          (clk),
		.resetd       (resetd),
		.i_sync       (i_sync),
		.i_mode       (i_mode),
		.o_vga_sync_n (o_vga_sync_n),
		.o_sync_pol   (o_sync_pol)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Run timed out after %0d cycles before all tests finished", cycle_cnt);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic bit [31:0] xorshift(input bit [31:0] s);
		bit [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic pick(input int lo, input int hi, output int val);
		rng_state = xorshift(rng_state);
		val = lo + int'(rng_state % 32'(hi - lo + 1));
	endtask

	function automatic cnt_t sat_inc(input cnt_t v);
		cnt_t r;
		if (v == '1) begin
			r = v;
		end else begin
			r = v + cnt_t'(1);
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model advanced by one clock edge per call
	////////////////////////////////////////////////////////////

	task automatic model_update();
		logic raw [2];
		logic norm [2];
		logic rise;
		logic fall;
		logic h_rise;
		logic h_fall;
		logic csync_now;
		logic new_pol;
		int   c;
		raw[0] = i_sync.hs;
		raw[1] = i_sync.vs;
		// Normalized sync is combinational and uses the polarity before the edge
		norm[0] = raw[0] ^ m_pol[0];
		norm[1] = raw[1] ^ m_pol[1];
		csync_now = m_serr ^ m_vs_q;
		if (resetd) begin
			for (c = 0; c < 2; c++) begin
				m_q1[c] = 1'b0;
				m_q2[c] = 1'b0;
				m_run[c] = '0;
				m_low[c] = '0;
				m_high[c] = '0;
				m_pol[c] = 1'b0;
			end
			m_hs_prev = 1'b0;
			m_h_cnt = '0;
			m_hs_len = '0;
			m_line_len = '0;
			m_serr = 1'b0;
			m_vs_q = 1'b0;
			m_out_n = '{hs: 1'b1, vs: 1'b1};
			m_pol_out = '{hs: 1'b0, vs: 1'b0};
		end else begin
			if (i_mode == SYNC_COMPOSITE) begin
				m_out_n.hs = ~csync_now;
				m_out_n.vs = 1'b1;
			end else begin
				m_out_n.hs = ~norm[0];
				m_out_n.vs = ~norm[1];
			end
			m_pol_out.hs = m_pol[0];
			m_pol_out.vs = m_pol[1];
			// Composite sync with the serration pulse set one sync length before the next line
			h_rise = norm[0] & ~m_hs_prev;
			h_fall = ~norm[0] & m_hs_prev;
			if (!norm[1]) begin
				m_serr = norm[0];
			end else if (m_h_cnt == m_line_len) begin
				m_serr = 1'b1;
			end else if (h_rise) begin
				m_serr = 1'b0;
			end
			if (h_rise) begin
				m_line_len = m_h_cnt - m_hs_len;
			end
			if (h_fall) begin
				m_hs_len = m_h_cnt;
			end
			m_h_cnt = (h_rise || h_fall) ? '0 : sat_inc(m_h_cnt);
			m_hs_prev = norm[0];
			m_vs_q = norm[1];
			// Run lengths seen at the end of the two-stage chain
			for (c = 0; c < 2; c++) begin
				rise = m_q1[c] & ~m_q2[c];
				fall = ~m_q1[c] & m_q2[c];
				new_pol = (m_high[c] > m_low[c]);
				if (rise) begin
					m_low[c] = m_run[c];
				end
				if (fall) begin
					m_high[c] = m_run[c];
				end
				m_run[c] = (rise || fall) ? '0 : sat_inc(m_run[c]);
				m_q2[c] = m_q1[c];
				m_q1[c] = raw[c];
				m_pol[c] = new_pol;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Inputs change on the rising edge, outputs compared on the falling edge
	task automatic step(input logic next_resetd, input sync_t next_sync,
		input sync_mode_e next_mode);
		@(posedge clk);
		model_update();
		resetd <= next_resetd;
		i_sync <= next_sync;
		i_mode <= next_mode;
		@(negedge clk);
		check_value("o_vga_sync_n.hs", o_vga_sync_n.hs, m_out_n.hs);
		check_value("o_vga_sync_n.vs", o_vga_sync_n.vs, m_out_n.vs);
		check_value("o_sync_pol.hs", o_sync_pol.hs, m_pol_out.hs);
		check_value("o_sync_pol.vs", o_sync_pol.vs, m_pol_out.vs);
	endtask

	// Polarity and mode are drawn fresh, so flips happen without a reset
	task automatic run_test(input int idx);
		int         line_len;
		int         hs_w;
		int         frame_h;
		int         vs_w;
		int         v;
		int         err_start;
		int         f;
		int         ln;
		int         x;
		logic       hp;
		logic       vp;
		sync_mode_e mode;
		sync_t      raw;
		// Gap of at least 21 cycles keeps the pulse the shorter run
		pick(41, 200, line_len);
		pick(4, 20, hs_w);
		pick(20, 40, frame_h);
		pick(2, 5, vs_w);
		pick(0, 1, v);
		hp = (v != 0);
		pick(0, 1, v);
		vp = (v != 0);
		pick(0, 1, v);
		mode = (v != 0) ? SYNC_COMPOSITE : SYNC_SEPARATE;
		err_start = err_count;
		for (f = 0; f < FRAMES_PER_TEST; f++) begin
			for (ln = 0; ln < frame_h; ln++) begin
				for (x = 0; x < line_len; x++) begin
					raw.hs = (x < hs_w) ^ hp;
					raw.vs = (ln < vs_w) ^ vp;
					step(1'b0, raw, mode);
				end
			end
			// Two full frames are enough for both detectors
			if (f == 1) begin
				check_value("o_sync_pol.hs vs stimulus", o_sync_pol.hs, hp);
				check_value("o_sync_pol.vs vs stimulus", o_sync_pol.vs, vp);
			end
		end
		$display("Test %0d done: line %0d hs %0d lines %0d vs %0d pol %b%b %s mode errors %0d",
			idx, line_len, hs_w, frame_h, vs_w, hp, vp,
			(mode == SYNC_COMPOSITE) ? "composite" : "separate", err_count - err_start);
		test_count++;
	endtask

	initial begin
		int i;
		resetd = 1'b1;
		i_sync = '{hs: 1'b0, vs: 1'b0};
		i_mode = SYNC_SEPARATE;
		rng_state = 32'h52cb9cf8;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			step((i < RESET_CYCLES - 1), '{hs: 1'b0, vs: 1'b0}, SYNC_SEPARATE);
		end
		for (i = 0; i < 4; i++) begin
			step(1'b0, '{hs: 1'b0, vs: 1'b0}, SYNC_SEPARATE);
		end
		check_value("o_vga_sync_n.hs after reset", o_vga_sync_n.hs, 1'b1);
		check_value("o_vga_sync_n.vs after reset", o_vga_sync_n.vs, 1'b1);
		check_value("o_sync_pol.hs after reset", o_sync_pol.hs, 1'b0);
		check_value("o_sync_pol.vs after reset", o_sync_pol.vs, 1'b0);
		$display("Test 0 done: reset state, errors %0d", err_count);
		test_count++;
		for (i = 1; i <= NUM_TESTS; i++) begin
			run_test(i);
		end
		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
src/sync_pkg.sv
src/sync_polarity_fix.sv
src/csync_gen.sv
src/video_sync_top.sv
test/video_sync_sva.sv
test/tb_video_sync.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_video_sync -f src.f > sim.log 2>&1 \
	&& ./obj_dir/Vtb_video_sync >> sim.log 2>&1 \
	|| echo "Build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
